/* hw/riscv_consts.svh */
// RV32I encoding constants for opcodes, funct fields and decoded code widths
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// datapath and field widths
`define XLEN        32
`define REG_ADDR_W  5
`define OPC_W       7
`define F3_W        3
`define F7_W        7
`define IMM_FMT_W   3

// widths of the decoded operation codes
`define EXU_OP_W    5               // 17 execute codes need five bits
`define EXU_SEL_W   2
`define LSU_OP_W    4

// major opcodes, inst[6:0]
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_OP      7'b0110011

// funct3 for OP and OP-IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 for jalr, only one value is legal
`define F3_JALR     3'b000

// funct3 for loads
`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101

// funct3 for stores
`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010

// funct3 for branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// funct7 values of the base integer set
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000      // sub, sra and srai

`endif

/* hw/isa_pkg.sv */
// instruction word package with the six RV32I format views and the immediate formats
`default_nettype none
`include "riscv_consts.svh"

package isa_pkg;

    typedef struct packed {
        logic [`F7_W-1:0]       funct7;
        logic [`REG_ADDR_W-1:0] rs2;        // also the shamt of slli/srli/srai
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPC_W-1:0]      opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm_11_0;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPC_W-1:0]      opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [4:0]             imm_4_0;
        logic [`OPC_W-1:0]      opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;     // sits where rd[0] would be
        logic [`OPC_W-1:0]      opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm_31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPC_W-1:0]      opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPC_W-1:0]      opcode;
    } j_fmt_t;

    // one 32-bit word, read through whichever view the format calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [`IMM_FMT_W-1:0] {
        IMM_NONE  = '0,
        IMM_I,
        IMM_SHAMT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

endpackage

`default_nettype wire

/* hw/ctrl_pkg.sv */
// decoded control package with the execute, select and load/store codes and the bundle
`default_nettype none
`include "riscv_consts.svh"

package ctrl_pkg;

    // branch compares get their own codes next to the arithmetic ones
    typedef enum logic [`EXU_OP_W-1:0] {
        EXU_NOP  = '0,                  // unknown instruction
        EXU_ADD,
        EXU_SUB,
        EXU_AND,
        EXU_OR,
        EXU_XOR,
        EXU_SLT,
        EXU_SLTU,
        EXU_SLL,
        EXU_SRL,
        EXU_SRA,
        EXU_BEQ,
        EXU_BNE,
        EXU_BLT,
        EXU_BGE,
        EXU_BLTU,
        EXU_BGEU
    } exu_op_e;

    typedef enum logic [`EXU_SEL_W-1:0] {
        SEL_RS1_RS2 = '0,               // also the unknown-instruction value
        SEL_RS1_IMM,
        SEL_PC_IMM,
        SEL_PC_4                        // link address for jal/jalr
    } exu_sel_e;

    typedef enum logic [`LSU_OP_W-1:0] {
        LSU_NONE = '0,
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_op_e;

    typedef struct packed {
        logic                   rd_wr_en;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`REG_ADDR_W-1:0] rs1_addr;
        logic [`REG_ADDR_W-1:0] rs2_addr;
        logic [`XLEN-1:0]       imm;
        logic                   jal_en;
        logic                   jalr_en;
        logic                   branch_en;
        exu_op_e                exu_op;
        exu_sel_e               exu_sel;
        lsu_op_e                lsu_op;
    } dec_ctrl_t;

endpackage

`default_nettype wire

/* hw/imm_gen.sv */
// immediate generator that assembles the 32-bit immediate for a given format
`timescale 1ns/1ps
`default_nettype none
`include "riscv_consts.svh"

module imm_gen (
    input  isa_pkg::inst_u    inst,
    input  isa_pkg::imm_fmt_e imm_fmt,
    output logic [`XLEN-1:0]  imm
);

    import isa_pkg::*;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_shamt;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    // sign always comes from inst[31]
    assign imm_i = {{(`XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};

    assign imm_shamt = {{(`XLEN-`REG_ADDR_W){1'b0}}, inst.r.rs2};     // zero extended

    assign imm_s = {{(`XLEN-12){inst.s.imm_11_5[6]}},
                    inst.s.imm_11_5,
                    inst.s.imm_4_0};

    assign imm_b = {{(`XLEN-13){inst.b.imm_12}},
                    inst.b.imm_12,
                    inst.b.imm_11,
                    inst.b.imm_10_5,
                    inst.b.imm_4_1,
                    1'b0};                                              // halfword aligned

    assign imm_u = {inst.u.imm_31_12, 12'b0};

    assign imm_j = {{(`XLEN-21){inst.j.imm_20}},
                    inst.j.imm_20,
                    inst.j.imm_19_12,
                    inst.j.imm_11,
                    inst.j.imm_10_1,
                    1'b0};

    always_comb begin
        case (imm_fmt)
            IMM_I:     imm = imm_i;
            IMM_SHAMT: imm = imm_shamt;
            IMM_S:     imm = imm_s;
            IMM_B:     imm = imm_b;
            IMM_U:     imm = imm_u;
            IMM_J:     imm = imm_j;
            default:   imm = '0;        // IMM_NONE and unused encodings
        endcase
    end

endmodule

`default_nettype wire

/* hw/ctrl_decode.sv */
// control decoder that classifies opcode, funct3 and funct7 into the RV32I control bundle
`timescale 1ns/1ps
`default_nettype none
`include "riscv_consts.svh"

module ctrl_decode (
    input  isa_pkg::inst_u      inst,
    output ctrl_pkg::dec_ctrl_t ctrl,
    output isa_pkg::imm_fmt_e   imm_fmt
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [`OPC_W-1:0] opcode;
    logic [`F3_W-1:0]  funct3;
    logic [`F7_W-1:0]  funct7;
    logic              f7_alt_ok;   // only add/sub and srl/sra may carry F7_ALT
    logic              f7_legal;
    exu_op_e           r_op;        // OP table op, shifts of OP-IMM reuse it
    logic              use_rd;
    logic              use_rs1;
    logic              use_rs2;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;

    assign f7_alt_ok = (funct3 == `F3_ADD_SUB) || (funct3 == `F3_SRL_SRA);
    assign f7_legal  = (funct7 == `F7_BASE) || ((funct7 == `F7_ALT) && f7_alt_ok);

    always_comb begin
        case (funct3)
            `F3_ADD_SUB: r_op = (funct7 == `F7_ALT) ? EXU_SUB : EXU_ADD;
            `F3_SLL:     r_op = EXU_SLL;
            `F3_SLT:     r_op = EXU_SLT;
            `F3_SLTU:    r_op = EXU_SLTU;
            `F3_XOR:     r_op = EXU_XOR;
            `F3_SRL_SRA: r_op = (funct7 == `F7_ALT) ? EXU_SRA : EXU_SRL;
            `F3_OR:      r_op = EXU_OR;
            `F3_AND:     r_op = EXU_AND;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.lsu_op = LSU_NONE;
        imm_fmt     = IMM_NONE;
        use_rd      = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;

        case (opcode)
            `OPC_LUI: begin                     // rd = x0 + imm
                use_rd       = 1'b1;
                ctrl.exu_op  = EXU_ADD;
                ctrl.exu_sel = SEL_RS1_IMM;
                imm_fmt      = IMM_U;
            end
            `OPC_AUIPC: begin                   // rd = pc + imm
                use_rd       = 1'b1;
                ctrl.exu_op  = EXU_ADD;
                ctrl.exu_sel = SEL_PC_IMM;
                imm_fmt      = IMM_U;
            end
            `OPC_JAL: begin                     // rd = pc + 4, target pc + imm
                use_rd       = 1'b1;
                ctrl.jal_en  = 1'b1;
                ctrl.exu_op  = EXU_ADD;
                ctrl.exu_sel = SEL_PC_4;
                imm_fmt      = IMM_J;
            end
            `OPC_JALR: begin
                if (funct3 == `F3_JALR) begin   // target rs1 + imm
                    use_rd       = 1'b1;
                    use_rs1      = 1'b1;
                    ctrl.jalr_en = 1'b1;
                    ctrl.exu_op  = EXU_ADD;
                    ctrl.exu_sel = SEL_PC_4;
                    imm_fmt      = IMM_I;
                end
            end
            `OPC_OP_IMM: begin
                if ((funct3 == `F3_SLL) || (funct3 == `F3_SRL_SRA)) begin
                    if (f7_legal) begin         // funct7 field picks srli or srai
                        use_rd       = 1'b1;
                        use_rs1      = 1'b1;
                        ctrl.exu_op  = r_op;
                        ctrl.exu_sel = SEL_RS1_IMM;
                        imm_fmt      = IMM_SHAMT;
                    end
                end else begin
                    use_rd       = 1'b1;
                    use_rs1      = 1'b1;
                    ctrl.exu_op  = (funct3 == `F3_ADD_SUB) ? EXU_ADD : r_op;    // no subi
                    ctrl.exu_sel = SEL_RS1_IMM;
                    imm_fmt      = IMM_I;
                end
            end
            `OPC_LOAD: begin
                case (funct3)
                    `F3_LB:  ctrl.lsu_op = LSU_LB;
                    `F3_LH:  ctrl.lsu_op = LSU_LH;
                    `F3_LW:  ctrl.lsu_op = LSU_LW;
                    `F3_LBU: ctrl.lsu_op = LSU_LBU;
                    `F3_LHU: ctrl.lsu_op = LSU_LHU;
                    default: ctrl.lsu_op = LSU_NONE;
                endcase
                if (ctrl.lsu_op != LSU_NONE) begin  // address is rs1 + imm
                    use_rd       = 1'b1;
                    use_rs1      = 1'b1;
                    ctrl.exu_op  = EXU_ADD;
                    ctrl.exu_sel = SEL_RS1_IMM;
                    imm_fmt      = IMM_I;
                end
            end
            `OPC_STORE: begin
                case (funct3)
                    `F3_SB:  ctrl.lsu_op = LSU_SB;
                    `F3_SH:  ctrl.lsu_op = LSU_SH;
                    `F3_SW:  ctrl.lsu_op = LSU_SW;
                    default: ctrl.lsu_op = LSU_NONE;
                endcase
                if (ctrl.lsu_op != LSU_NONE) begin  // rs2 carries the store data
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    ctrl.exu_op  = EXU_ADD;
                    ctrl.exu_sel = SEL_RS1_IMM;
                    imm_fmt      = IMM_S;
                end
            end
            `OPC_BRANCH: begin
                case (funct3)
                    `F3_BEQ:  ctrl.exu_op = EXU_BEQ;
                    `F3_BNE:  ctrl.exu_op = EXU_BNE;
                    `F3_BLT:  ctrl.exu_op = EXU_BLT;
                    `F3_BGE:  ctrl.exu_op = EXU_BGE;
                    `F3_BLTU: ctrl.exu_op = EXU_BLTU;
                    `F3_BGEU: ctrl.exu_op = EXU_BGEU;
                    default:  ctrl.exu_op = EXU_NOP;
                endcase
                if (ctrl.exu_op != EXU_NOP) begin   // compare rs1 with rs2
                    use_rs1        = 1'b1;
                    use_rs2        = 1'b1;
                    ctrl.branch_en = 1'b1;
                    ctrl.exu_sel   = SEL_RS1_RS2;
                    imm_fmt        = IMM_B;
                end
            end
            `OPC_OP: begin
                if (f7_legal) begin             // M extension funct7 falls out here
                    use_rd       = 1'b1;
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    ctrl.exu_op  = r_op;
                    ctrl.exu_sel = SEL_RS1_RS2;
                end
            end
            default: ;                          // unknown opcode keeps the zero bundle
        endcase

        // register fields only when the format uses them
        ctrl.rd_wr_en = use_rd;
        ctrl.rd_addr  = use_rd  ? inst.r.rd  : '0;
        ctrl.rs1_addr = use_rs1 ? inst.r.rs1 : '0;
        ctrl.rs2_addr = use_rs2 ? inst.r.rs2 : '0;
    end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
// RV32I decode stage that registers the merged control bundle one cycle after the strobe
`timescale 1ns/1ps
`default_nettype none
`include "riscv_consts.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  logic [`XLEN-1:0]    inst,
    output logic                dec_valid,
    output ctrl_pkg::dec_ctrl_t dec
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    inst_u            inst_view;
    imm_fmt_e         imm_fmt;
    logic [`XLEN-1:0] imm;
    dec_ctrl_t        ctrl;
    dec_ctrl_t        merged;

    assign inst_view = inst;

    ctrl_decode u_ctrl (
        .inst    (inst_view),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm (
        .inst    (inst_view),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    always_comb begin
        merged     = ctrl;
        merged.imm = imm;               // ctrl_decode leaves imm at zero
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid  <= 1'b0;
            dec        <= '0;
            dec.lsu_op <= LSU_NONE;
        end else begin
            dec_valid <= inst_valid;    // one cycle pulse per strobe
            if (inst_valid) begin
                dec <= merged;          // held across idle cycles
            end
        end
    end

    // the output strobe is the input strobe delayed by exactly one cycle
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        1'b1 |=> (dec_valid == $past(inst_valid))
    );

    a_one_jump_kind: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> $onehot0({dec.jal_en, dec.jalr_en, dec.branch_en})
    );

    // stores never write back
    a_store_no_rd: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> !(dec.rd_wr_en && (dec.lsu_op inside {LSU_SB, LSU_SH, LSU_SW}))
    );

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
// testbench clock generator with a 40 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk
);

    localparam time HALF_PERIOD = 20;   // 40 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* dv/tb_decode_stage.sv */
// testbench for the RV32I decode stage with a reference decoder and a checking process
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    import ctrl_pkg::*;

    localparam int N_INST     = 400;
    localparam int CLK_PERIOD = 40;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        dec_valid;
    dec_ctrl_t   dec;

    dec_ctrl_t   exp_q[$];          // expected bundles in issue order
    logic [31:0] inst_q[$];
    int unsigned due_q[$];          // cycle in which each bundle must come out
    int unsigned cycle;             // rising edges seen so far
    dec_ctrl_t   last_exp;          // what dec must hold while idle
    logic [31:0] last_inst;
    logic        exp_valid;

    tb_clkgen u_clk (
        .clk (clk)
    );

    decode_stage dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    task automatic report_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    // OP and OP-IMM operation or EXU_NOP for an illegal funct7
    function automatic exu_op_e alu_ref(input logic [2:0] f3, input logic [6:0] f7,
                                        input logic imm_form);
        logic base;
        logic alt;
        base = (f7 == 7'h00);
        alt  = (f7 == 7'h20);
        if (!imm_form && !base && !(alt && (f3 == 3'b000 || f3 == 3'b101)))
            return EXU_NOP;
        case (f3)
            3'b000:  return (alt && !imm_form) ? EXU_SUB : EXU_ADD;
            3'b001:  return base ? EXU_SLL : EXU_NOP;
            3'b010:  return EXU_SLT;
            3'b011:  return EXU_SLTU;
            3'b100:  return EXU_XOR;
            3'b101:  return base ? EXU_SRL : (alt ? EXU_SRA : EXU_NOP);
            3'b110:  return EXU_OR;
            default: return EXU_AND;
        endcase
    endfunction

    function automatic dec_ctrl_t ref_decode(input logic [31:0] w);
        dec_ctrl_t  d;
        logic [2:0] f3;
        logic       has_rd;
        logic       has_rs1;
        logic       has_rs2;
        d       = '0;
        f3      = w[14:12];
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        case (w[6:0])
            7'b0110111, 7'b0010111: begin                   // lui, auipc
                has_rd    = 1'b1;
                d.exu_op  = EXU_ADD;
                d.exu_sel = w[4] && !w[5] ? SEL_PC_IMM : SEL_RS1_IMM;
                d.imm     = {w[31:12], 12'b0};
            end
            7'b1101111: begin                               // jal
                has_rd    = 1'b1;
                d.jal_en  = 1'b1;
                d.exu_op  = EXU_ADD;
                d.exu_sel = SEL_PC_4;
                d.imm     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111: begin                               // jalr
                if (f3 == 3'b000) begin
                    has_rd    = 1'b1;
                    has_rs1   = 1'b1;
                    d.jalr_en = 1'b1;
                    d.exu_op  = EXU_ADD;
                    d.exu_sel = SEL_PC_4;
                    d.imm     = {{20{w[31]}}, w[31:20]};
                end
            end
            7'b0010011: begin                               // OP-IMM
                d.exu_op = alu_ref(f3, w[31:25], 1'b1);
                if (d.exu_op != EXU_NOP) begin
                    has_rd    = 1'b1;
                    has_rs1   = 1'b1;
                    d.exu_sel = SEL_RS1_IMM;
                    d.imm     = (f3[1:0] == 2'b01) ? {27'b0, w[24:20]} : {{20{w[31]}}, w[31:20]};
                end
            end
            7'b0000011: begin                               // loads
                case (f3)
                    3'b000:  d.lsu_op = LSU_LB;
                    3'b001:  d.lsu_op = LSU_LH;
                    3'b010:  d.lsu_op = LSU_LW;
                    3'b100:  d.lsu_op = LSU_LBU;
                    3'b101:  d.lsu_op = LSU_LHU;
                    default: d.lsu_op = LSU_NONE;
                endcase
                if (d.lsu_op != LSU_NONE) begin
                    has_rd    = 1'b1;
                    has_rs1   = 1'b1;
                    d.exu_op  = EXU_ADD;
                    d.exu_sel = SEL_RS1_IMM;
                    d.imm     = {{20{w[31]}}, w[31:20]};
                end
            end
            7'b0100011: begin                               // stores
                case (f3)
                    3'b000:  d.lsu_op = LSU_SB;
                    3'b001:  d.lsu_op = LSU_SH;
                    3'b010:  d.lsu_op = LSU_SW;
                    default: d.lsu_op = LSU_NONE;
                endcase
                if (d.lsu_op != LSU_NONE) begin
                    has_rs1   = 1'b1;
                    has_rs2   = 1'b1;
                    d.exu_op  = EXU_ADD;
                    d.exu_sel = SEL_RS1_IMM;
                    d.imm     = {{20{w[31]}}, w[31:25], w[11:7]};
                end
            end
            7'b1100011: begin                               // branches
                case (f3)
                    3'b000:  d.exu_op = EXU_BEQ;
                    3'b001:  d.exu_op = EXU_BNE;
                    3'b100:  d.exu_op = EXU_BLT;
                    3'b101:  d.exu_op = EXU_BGE;
                    3'b110:  d.exu_op = EXU_BLTU;
                    3'b111:  d.exu_op = EXU_BGEU;
                    default: d.exu_op = EXU_NOP;
                endcase
                if (d.exu_op != EXU_NOP) begin
                    has_rs1     = 1'b1;
                    has_rs2     = 1'b1;
                    d.branch_en = 1'b1;
                    d.exu_sel   = SEL_RS1_RS2;
                    d.imm       = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'b0110011: begin                               // OP
                d.exu_op = alu_ref(f3, w[31:25], 1'b0);
                if (d.exu_op != EXU_NOP) begin
                    has_rd    = 1'b1;
                    has_rs1   = 1'b1;
                    has_rs2   = 1'b1;
                    d.exu_sel = SEL_RS1_RS2;
                end
            end
            default: ;
        endcase
        d.rd_wr_en = has_rd;
        d.rd_addr  = has_rd  ? w[11:7]  : 5'd0;
        d.rs1_addr = has_rs1 ? w[19:15] : 5'd0;
        d.rs2_addr = has_rs2 ? w[24:20] : 5'd0;
        return d;
    endfunction

    // random fields on top of a fixed opcode, funct3 or funct7 per instruction class
    function automatic logic [31:0] rand_inst(input int unsigned kind);
        logic [31:0] w;
        w = $urandom;
        case (kind)
            0: w[6:0] = 7'b0110111;
            1: w[6:0] = 7'b0010111;
            2: w[6:0] = 7'b1101111;
            3: begin
                w[6:0]   = 7'b1100111;
                w[14:12] = 3'b000;
            end
            4: begin
                w[6:0] = 7'b0010011;
                if (w[13:12] == 2'b01)
                    w[31:25] = {1'b0, w[30], 5'b0};         // base or alt funct7 on shifts
            end
            5: w[6:0] = 7'b0000011;
            6: begin
                w[6:0] = 7'b0100011;
                w[14]  = 1'b0;
            end
            7: w[6:0] = 7'b1100011;
            8: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = {1'b0, w[30], 5'b0};
            end
            9: begin                                        // M extension
                w[6:0]   = 7'b0110011;
                w[31:25] = 7'b0000001;
            end
            10: w[6:0] = 7'b0110011;                        // mostly bad funct7
            default: ;                                      // fully random word
        endcase
        return w;
    endfunction

    task automatic send_inst(input logic [31:0] w);
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst       = w;
        exp_q.push_back(ref_decode(w));
        inst_q.push_back(w);
        due_q.push_back(cycle + 1);     // captured at the next rising edge
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        inst       = $urandom;      // junk while the strobe is low
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(negedge clk) begin : compare_out
        if (rst_n) begin
            exp_valid = (due_q.size() > 0) && (due_q[0] == cycle);
            assert (dec_valid === exp_valid) else begin
                $display("error at %0t ns: dec_valid is %b, expected %b",
                         $time, dec_valid, exp_valid);
                report_failure();
            end
            if (dec_valid) begin
                last_exp  = exp_q.pop_front();
                last_inst = inst_q.pop_front();
                void'(due_q.pop_front());
            end
            assert (dec === last_exp) else begin
                $display("error at %0t ns: inst %h, expected %h, got %h",
                         $time, last_inst, last_exp, dec);
                report_failure();
            end
        end
    end

    initial begin
        #((N_INST * 2 + 50) * CLK_PERIOD);
        $display("timeout: the decode run did not finish in time");
        report_failure();
    end

    initial begin
        int unsigned seed;
        seed       = 97;
        void'($urandom(seed));
        last_exp   = '0;            // reset bundle with lsu_op at LSU_NONE
        last_inst  = '0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int n = 0; n < N_INST; n++) begin
            if ($urandom_range(2, 0) == 0)
                idle_cycle();       // otherwise strobes go back to back
            send_inst(rand_inst($urandom_range(11, 0)));
        end
        repeat (3) idle_cycle();

        if (exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d decoded bundles never came out of the DUT", exp_q.size());
            report_failure();
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/imm_gen.sv
hw/ctrl_decode.sv
hw/decode_stage.sv
dv/tb_clkgen.sv
dv/tb_decode_stage.sv

/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tb_decode_stage
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(SIM), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
